// ==== source/tile_consts.svh ====
//**********************************************************
// host tile constants
//**********************************************************

`ifndef TILE_CONSTS_SVH
`define TILE_CONSTS_SVH

// data ram size in 32-bit words
`define TILE_MEM_WORDS          1024

// address decode
`define TILE_XIF_BITSEL         31
`define TILE_SFR_BITSEL         20

// log2 of interrupt line count
`define TILE_IRQ_NUM_POW        4

`define TILE_CORENUM            32'h0000_0001
`define TILE_SW_RESET_DEFAULT   1'b0

// sfr byte offsets
`define TILE_SFR_ID             8'h00
`define TILE_SFR_SWRST          8'h04
`define TILE_SFR_IRQEN          8'h08
`define TILE_SFR_TPERIOD        8'h0C
`define TILE_SFR_TVALUE         8'h10
`define TILE_SFR_SGI            8'h14

`endif

// ==== source/tile_pkg.sv ====
//**********************************************************
// host tile types
//**********************************************************

`include "tile_consts.svh"

package tile_pkg;

    // split-transaction request word
    typedef struct packed
    {
        logic        we;
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] wdata;
    } mem_req_t;

    typedef enum logic
    {
        RT_IDLE,
        RT_WAIT_RESP
    } router_state_e;

    // decoded slave
    typedef enum logic [1:0]
    {
        TGT_DMEM,
        TGT_SFR,
        TGT_XIF
    } target_e;

    typedef logic [`TILE_IRQ_NUM_POW-1:0] irq_code_t;

endpackage

// ==== source/bus_router.sv ====
//**********************************************************
// host bus router
//**********************************************************

`timescale 1ns/100ps

`include "tile_consts.svh"

module bus_router
    import tile_pkg::*;
(
    input  logic          clk_i
    , input  logic        reset_i

    , input  logic        hif_req_i
    , input  mem_req_t    hif_req_data_i
    , output logic        hif_ack_o
    , output logic        hif_resp_o
    , output logic [31:0] hif_rdata_o

    , output logic        dmem_req_o
    , input  logic        dmem_ack_i
    , input  logic        dmem_resp_i
    , input  logic [31:0] dmem_rdata_i

    , output logic        sfr_req_o
    , input  logic        sfr_ack_i
    , input  logic        sfr_resp_i
    , input  logic [31:0] sfr_rdata_i

    , output logic        xif_req_o
    , input  logic        xif_ack_i
    , input  logic        xif_resp_i
    , input  logic [31:0] xif_rdata_i

    , output mem_req_t    tgt_req_data_o
);

    router_state_e state;
    target_e       req_tgt;
    target_e       resp_tgt;
    logic          idle_req;
    logic          sel_ack;
    logic          sel_resp;

    // expansion bit wins over the sfr bit
    always_comb
    begin
        if (hif_req_data_i.addr[`TILE_XIF_BITSEL])
            req_tgt = TGT_XIF;
        else if (hif_req_data_i.addr[`TILE_SFR_BITSEL])
            req_tgt = TGT_SFR;
        else
            req_tgt = TGT_DMEM;
    end

    assign idle_req   = hif_req_i && (state == RT_IDLE);
    assign dmem_req_o = idle_req && (req_tgt == TGT_DMEM);
    assign sfr_req_o  = idle_req && (req_tgt == TGT_SFR);
    assign xif_req_o  = idle_req && (req_tgt == TGT_XIF);

    assign tgt_req_data_o = hif_req_data_i;

    always_comb
    begin
        case (req_tgt)
            TGT_SFR:  sel_ack = sfr_ack_i;
            TGT_XIF:  sel_ack = xif_ack_i;
            default:  sel_ack = dmem_ack_i;
        endcase
    end

    assign hif_ack_o = idle_req && sel_ack;

    // response comes back from the target of the pending read
    always_comb
    begin
        case (resp_tgt)
            TGT_SFR:
            begin
                sel_resp    = sfr_resp_i;
                hif_rdata_o = sfr_rdata_i;
            end
            TGT_XIF:
            begin
                sel_resp    = xif_resp_i;
                hif_rdata_o = xif_rdata_i;
            end
            default:
            begin
                sel_resp    = dmem_resp_i;
                hif_rdata_o = dmem_rdata_i;
            end
        endcase
    end

    assign hif_resp_o = (state == RT_WAIT_RESP) && sel_resp;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            state    <= RT_IDLE;
            resp_tgt <= TGT_DMEM;
        end
        else
        begin
            case (state)
                RT_IDLE:
                begin
                    if (hif_ack_o && !hif_req_data_i.we)
                    begin
                        state    <= RT_WAIT_RESP;
                        resp_tgt <= req_tgt;
                    end
                end
                default:
                begin
                    if (hif_resp_o)
                        state <= RT_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== source/data_ram.sv ====
//**********************************************************
// local data ram
//**********************************************************

`timescale 1ns/100ps

`include "tile_consts.svh"

module data_ram
    import tile_pkg::*;
(
    input  logic          clk_i
    , input  logic        req_i
    , input  mem_req_t    req_data_i
    , output logic        ack_o
    , output logic        resp_o
    , output logic [31:0] rdata_o
);

    localparam int ADDR_W = $clog2(`TILE_MEM_WORDS);

    logic [31:0]       mem [`TILE_MEM_WORDS];
    logic [ADDR_W-1:0] word_idx;
    logic              rd_en;
    logic              wr_en;

    // word address without the byte offset
    assign word_idx = req_data_i.addr[ADDR_W+1:2];

    assign ack_o = req_i;
    assign wr_en = req_i && req_data_i.we;
    assign rd_en = req_i && !req_data_i.we;

    always_ff @(posedge clk_i)
    begin
        if (wr_en)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (req_data_i.be[i])
                    mem[word_idx][8*i +: 8] <= req_data_i.wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        resp_o <= rd_en;
        if (rd_en)
            rdata_o <= mem[word_idx];
    end

endmodule

// ==== source/sfr_block.sv ====
//**********************************************************
// special-function registers
//**********************************************************

`timescale 1ns/100ps

`include "tile_consts.svh"

module sfr_block
    import tile_pkg::*;
(
    input  logic                               clk_i
    , input  logic                             reset_i
    , input  logic                             req_i
    , input  mem_req_t                         req_data_i
    , output logic                             ack_o
    , output logic                             resp_o
    , output logic [31:0]                      rdata_o
    , output logic                             sw_reset_o
    , output logic [(2**`TILE_IRQ_NUM_POW)-1:0] irq_en_o
    , output logic                             timer_tick_o
    , output logic                             sgi_req_o
    , output irq_code_t                        sgi_code_o
);

    localparam int IRQ_NUM = 2 ** `TILE_IRQ_NUM_POW;

    logic [7:0]  offs;
    logic        wr_en;
    logic        rd_en;
    logic [31:0] tperiod;
    logic [31:0] tvalue;
    logic [31:0] rd_word;

    assign offs  = req_data_i.addr[7:0];
    assign ack_o = req_i;
    assign wr_en = req_i && req_data_i.we;
    assign rd_en = req_i && !req_data_i.we;

    always_comb
    begin
        case (offs)
            `TILE_SFR_ID:      rd_word = `TILE_CORENUM;
            `TILE_SFR_SWRST:   rd_word = {31'd0, sw_reset_o};
            `TILE_SFR_IRQEN:   rd_word = {{(32-IRQ_NUM){1'b0}}, irq_en_o};
            `TILE_SFR_TPERIOD: rd_word = tperiod;
            `TILE_SFR_TVALUE:  rd_word = tvalue;
            default:           rd_word = 32'd0;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            sw_reset_o   <= `TILE_SW_RESET_DEFAULT;
            irq_en_o     <= '0;
            tperiod      <= 32'd0;
            tvalue       <= 32'd0;
            timer_tick_o <= 1'b0;
            sgi_req_o    <= 1'b0;
            resp_o       <= 1'b0;
        end
        else
        begin
            resp_o    <= rd_en;
            sgi_req_o <= wr_en && (offs == `TILE_SFR_SGI);

            if (wr_en && (offs == `TILE_SFR_SWRST))
                sw_reset_o <= req_data_i.wdata[0];
            if (wr_en && (offs == `TILE_SFR_IRQEN))
                irq_en_o <= req_data_i.wdata[IRQ_NUM-1:0];
            if (wr_en && (offs == `TILE_SFR_TPERIOD))
                tperiod <= req_data_i.wdata;

            // free-running timer that stops while period is zero
            timer_tick_o <= 1'b0;
            if (wr_en && (offs == `TILE_SFR_TVALUE))
                tvalue <= req_data_i.wdata;
            else if (tperiod != 32'd0)
            begin
                if (tvalue >= (tperiod - 32'd1))
                begin
                    tvalue       <= 32'd0;
                    timer_tick_o <= 1'b1;
                end
                else
                    tvalue <= tvalue + 32'd1;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rd_en)
            rdata_o <= rd_word;
        if (wr_en && (offs == `TILE_SFR_SGI))
            sgi_code_o <= req_data_i.wdata[`TILE_IRQ_NUM_POW-1:0];
    end

endmodule

// ==== source/irq_adapter.sv ====
//**********************************************************
// interrupt adapter
//**********************************************************

`timescale 1ns/100ps

`include "tile_consts.svh"

module irq_adapter
    import tile_pkg::*;
(
    input  logic                               clk_i
    , input  logic                             reset_i
    , input  logic                             soft_clear_i
    , input  logic [(2**`TILE_IRQ_NUM_POW)-1:0] irq_lines_i
    , input  logic [(2**`TILE_IRQ_NUM_POW)-1:0] irq_en_i
    , input  logic                             timer_tick_i
    , input  logic                             sgi_req_i
    , input  irq_code_t                        sgi_code_i
    , output logic                             irq_req_o
    , output irq_code_t                        irq_code_o
    , input  logic                             irq_ack_i
);

    localparam int IRQ_NUM = 2 ** `TILE_IRQ_NUM_POW;

    logic [IRQ_NUM-1:0] pending;
    logic [IRQ_NUM-1:0] hw_set;
    logic [IRQ_NUM-1:0] sgi_set;
    logic [IRQ_NUM-1:0] ack_clr;

    // timer tick shares line 1
    assign hw_set = (irq_lines_i | {{(IRQ_NUM-2){1'b0}}, timer_tick_i, 1'b0}) & irq_en_i;

    // software interrupt bypasses the mask
    assign sgi_set = {{(IRQ_NUM-1){1'b0}}, sgi_req_i} << sgi_code_i;

    assign ack_clr = {{(IRQ_NUM-1){1'b0}}, irq_ack_i && irq_req_o} << irq_code_o;

    assign irq_req_o = |pending;

    // lowest pending index wins
    always_comb
    begin
        irq_code_o = '0;
        for (int i = IRQ_NUM - 1; i >= 0; i--)
        begin
            if (pending[i])
                irq_code_o = irq_code_t'(i);
        end
    end

    // ack wins and a held line returns on the next edge
    always_ff @(posedge clk_i)
    begin
        if (reset_i || soft_clear_i)
            pending <= '0;
        else
            pending <= (pending | hw_set | sgi_set) & ~ack_clr;
    end

endmodule

// ==== source/host_tile.sv ====
//**********************************************************
// host tile top
//**********************************************************

`timescale 1ns/100ps

`include "tile_consts.svh"

module host_tile
    import tile_pkg::*;
(
    input  logic                               clk_i
    , input  logic                             reset_i

    , input  logic                             hif_req_i
    , input  mem_req_t                         hif_req_data_i
    , output logic                             hif_ack_o
    , output logic                             hif_resp_o
    , output logic [31:0]                      hif_rdata_o

    , output logic                             xif_req_o
    , output mem_req_t                         xif_req_data_o
    , input  logic                             xif_ack_i
    , input  logic                             xif_resp_i
    , input  logic [31:0]                      xif_rdata_i

    , input  logic [(2**`TILE_IRQ_NUM_POW)-1:0] irq_lines_i
    , output logic                             irq_req_o
    , output irq_code_t                        irq_code_o
    , input  logic                             irq_ack_i
);

    mem_req_t    tgt_req;
    logic        dmem_req;
    logic        dmem_ack;
    logic        dmem_resp;
    logic [31:0] dmem_rdata;
    logic        sfr_req;
    logic        sfr_ack;
    logic        sfr_resp;
    logic [31:0] sfr_rdata;

    logic                               sw_reset;
    logic [(2**`TILE_IRQ_NUM_POW)-1:0]  irq_en;
    logic                               timer_tick;
    logic                               sgi_req;
    irq_code_t                          sgi_code;

    // one request word is shared by all slaves
    assign xif_req_data_o = tgt_req;

    bus_router router (
        .clk_i            (clk_i)
        , .reset_i        (reset_i)
        , .hif_req_i      (hif_req_i)
        , .hif_req_data_i (hif_req_data_i)
        , .hif_ack_o      (hif_ack_o)
        , .hif_resp_o     (hif_resp_o)
        , .hif_rdata_o    (hif_rdata_o)
        , .dmem_req_o     (dmem_req)
        , .dmem_ack_i     (dmem_ack)
        , .dmem_resp_i    (dmem_resp)
        , .dmem_rdata_i   (dmem_rdata)
        , .sfr_req_o      (sfr_req)
        , .sfr_ack_i      (sfr_ack)
        , .sfr_resp_i     (sfr_resp)
        , .sfr_rdata_i    (sfr_rdata)
        , .xif_req_o      (xif_req_o)
        , .xif_ack_i      (xif_ack_i)
        , .xif_resp_i     (xif_resp_i)
        , .xif_rdata_i    (xif_rdata_i)
        , .tgt_req_data_o (tgt_req)
    );

    data_ram ram (
        .clk_i        (clk_i)
        , .req_i      (dmem_req)
        , .req_data_i (tgt_req)
        , .ack_o      (dmem_ack)
        , .resp_o     (dmem_resp)
        , .rdata_o    (dmem_rdata)
    );

    sfr_block sfr (
        .clk_i          (clk_i)
        , .reset_i      (reset_i)
        , .req_i        (sfr_req)
        , .req_data_i   (tgt_req)
        , .ack_o        (sfr_ack)
        , .resp_o       (sfr_resp)
        , .rdata_o      (sfr_rdata)
        , .sw_reset_o   (sw_reset)
        , .irq_en_o     (irq_en)
        , .timer_tick_o (timer_tick)
        , .sgi_req_o    (sgi_req)
        , .sgi_code_o   (sgi_code)
    );

    irq_adapter irq (
        .clk_i          (clk_i)
        , .reset_i      (reset_i)
        , .soft_clear_i (sw_reset)
        , .irq_lines_i  (irq_lines_i)
        , .irq_en_i     (irq_en)
        , .timer_tick_i (timer_tick)
        , .sgi_req_i    (sgi_req)
        , .sgi_code_i   (sgi_code)
        , .irq_req_o    (irq_req_o)
        , .irq_code_o   (irq_code_o)
        , .irq_ack_i    (irq_ack_i)
    );

endmodule

// ==== tests/tile_tb.sv ====
//**********************************************************
// host tile testbench
//**********************************************************

`timescale 1ns/100ps

`include "tile_consts.svh"

module tile_tb
    import tile_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int SAMPLE_DLY      = 40;
    localparam int REQ_TIMEOUT     = 40;
    localparam int WATCHDOG_CYCLES = 2 * (20 + 120 + 120 + 220 + 100 + 100);
    localparam int SFR_P           = 13;
    localparam int TIMER_P         = 6;
    localparam logic [31:0] RAM_BASE = 32'h0000_0100;
    localparam logic [31:0] XIF_BASE = (32'd1 << `TILE_XIF_BITSEL) | 32'h0000_0100;

    logic                              clk;
    logic                              reset;
    logic                              hif_req;
    mem_req_t                          hif_req_data;
    logic                              hif_ack;
    logic                              hif_resp;
    logic [31:0]                       hif_rdata;
    logic                              xif_req;
    mem_req_t                          xif_req_data;
    logic                              xif_ack;
    logic                              xif_resp;
    logic [31:0]                       xif_rdata;
    logic [(2**`TILE_IRQ_NUM_POW)-1:0] irq_lines;
    logic                              irq_req;
    irq_code_t                         irq_code;
    logic                              irq_ack;

    integer      seed = 32'hb7ea9af2;
    int          errors = 0;
    int          tests_run = 0;
    int          cycles = 0;
    int          wait_cycles;
    int          accept_cycle;
    int          xif_last_delay;
    mem_req_t    xif_last_req;
    logic [31:0] xif_mem [logic [31:0]];
    logic [31:0] ram_model [8];

    host_tile dut_i (
        .clk_i            (clk)
        , .reset_i        (reset)
        , .hif_req_i      (hif_req)
        , .hif_req_data_i (hif_req_data)
        , .hif_ack_o      (hif_ack)
        , .hif_resp_o     (hif_resp)
        , .hif_rdata_o    (hif_rdata)
        , .xif_req_o      (xif_req)
        , .xif_req_data_o (xif_req_data)
        , .xif_ack_i      (xif_ack)
        , .xif_resp_i     (xif_resp)
        , .xif_rdata_i    (xif_rdata)
        , .irq_lines_i    (irq_lines)
        , .irq_req_o      (irq_req)
        , .irq_code_o     (irq_code)
        , .irq_ack_i      (irq_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
        cycles <= cycles + 1;

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
                res[8*b +: 8] = new_word[8*b +: 8];
        end
        return res;
    endfunction

    // fill pattern of unwritten words uses every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0] ^ 16'h3c5a, addr[31:16] ^ addr[15:0]};
    endfunction

    function automatic logic [31:0] sfr_addr(input logic [7:0] offs);
        return (32'd1 << `TILE_SFR_BITSEL) | {24'd0, offs};
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [31:0] key;
        key = {addr[31:2], 2'b00};
        if (xif_mem.exists(key))
            return xif_mem[key];
        return fill_word(key);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
        errors = errors + 1;
    endtask

    task automatic close_test(input string name, input int err_before);
        tests_run = tests_run + 1;
        $display("%s: %0d error(s)", name, errors - err_before);
    endtask

    task automatic wait_sample();
        @(negedge clk);
        #(SAMPLE_DLY);
    endtask

    // drives one request and holds it until the accepting edge
    task automatic issue_request(input logic we, input logic [31:0] addr,
                                 input logic [3:0] be, input logic [31:0] wdata);
        int   n;
        logic done;
        n = 0;
        done = 1'b0;
        @(negedge clk);
        hif_req            = 1'b1;
        hif_req_data.we    = we;
        hif_req_data.addr  = addr;
        hif_req_data.be    = be;
        hif_req_data.wdata = wdata;
        while (!done && (n < REQ_TIMEOUT))
        begin
            #(SAMPLE_DLY);
            if (hif_ack)
            begin
                done = 1'b1;
                accept_cycle = cycles;
            end
            else
            begin
                n = n + 1;
                @(negedge clk);
            end
        end
        wait_cycles = n;
        if (!done)
        begin
            $display("request to address %h was never acknowledged", addr);
            errors = errors + 1;
        end
        @(negedge clk);
        hif_req = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata);
        issue_request(1'b1, addr, be, wdata);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
        int   n;
        logic done;
        n = 0;
        done = 1'b0;
        rdata = 32'd0;
        issue_request(1'b0, addr, 4'hf, 32'd0);
        while (!done && (n < REQ_TIMEOUT))
        begin
            #(SAMPLE_DLY);
            if (hif_resp)
            begin
                done = 1'b1;
                rdata = hif_rdata;
            end
            else
            begin
                n = n + 1;
                @(negedge clk);
            end
        end
        if (!done)
        begin
            $display("read from address %h got no response", addr);
            errors = errors + 1;
        end
    endtask

    task automatic ack_irq();
        @(negedge clk);
        irq_ack = 1'b1;
        @(negedge clk);
        irq_ack = 1'b0;
        #(SAMPLE_DLY);
    endtask

    task automatic pulse_lines(input logic [(2**`TILE_IRQ_NUM_POW)-1:0] mask);
        @(negedge clk);
        irq_lines = mask;
        @(negedge clk);
        irq_lines = '0;
        #(SAMPLE_DLY);
    endtask

    task automatic ram_test();
        int          e0;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rd;
        e0 = errors;
        for (int i = 0; i < 8; i++)
        begin
            addr = RAM_BASE + 32'(4 * i);
            ram_model[i] = fill_word(addr);
            bus_write(addr, 4'hf, ram_model[i]);
        end
        for (int i = 0; i < 8; i++)
        begin
            addr = RAM_BASE + 32'(4 * i);
            wdata = $random(seed);
            ram_model[i] = merge_bytes(ram_model[i], wdata, 4'(i + 1));
            bus_write(addr, 4'(i + 1), wdata);
        end
        for (int i = 0; i < 8; i++)
        begin
            bus_read(RAM_BASE + 32'(4 * i), rd);
            if (rd !== ram_model[i])
                report_mismatch("hif_rdata_o", ram_model[i], rd);
        end
        close_test("ram", e0);
    endtask

    task automatic sfr_test();
        int          e0;
        int          c1;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] exp;
        logic [31:0] rd;
        e0 = errors;
        bus_read(sfr_addr(`TILE_SFR_ID), rd);
        if (rd !== `TILE_CORENUM)
            report_mismatch("hif_rdata_o", `TILE_CORENUM, rd);
        bus_write(sfr_addr(`TILE_SFR_IRQEN), 4'hf, 32'h0000_a5c3);
        bus_read(sfr_addr(`TILE_SFR_IRQEN), rd);
        if (rd !== 32'h0000_a5c3)
            report_mismatch("hif_rdata_o", 32'h0000_a5c3, rd);
        bus_write(sfr_addr(`TILE_SFR_IRQEN), 4'hf, 32'd0);
        for (int v = 1; v >= 0; v--)
        begin
            bus_write(sfr_addr(`TILE_SFR_SWRST), 4'hf, 32'(v));
            bus_read(sfr_addr(`TILE_SFR_SWRST), rd);
            if (rd !== 32'(v))
                report_mismatch("hif_rdata_o", 32'(v), rd);
        end

        // timer advances one step per cycle modulo the period
        bus_write(sfr_addr(`TILE_SFR_TVALUE), 4'hf, 32'd0);
        bus_write(sfr_addr(`TILE_SFR_TPERIOD), 4'hf, 32'(SFR_P));
        bus_read(sfr_addr(`TILE_SFR_TVALUE), v1);
        c1 = accept_cycle;
        repeat (7) wait_sample();
        bus_read(sfr_addr(`TILE_SFR_TVALUE), v2);
        exp = (v1 + 32'(accept_cycle - c1)) % 32'(SFR_P);
        if (v2 !== exp)
            report_mismatch("hif_rdata_o", exp, v2);
        bus_write(sfr_addr(`TILE_SFR_TPERIOD), 4'hf, 32'd0);
        close_test("sfr", e0);
    endtask

    task automatic xif_test();
        int          e0;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic [31:0] rd;
        logic [31:0] xexp [6];
        e0 = errors;
        for (int i = 0; i < 6; i++)
        begin
            addr = XIF_BASE + 32'(4 * i);
            be = 4'(2 * i + 3);
            wdata = $random(seed);
            xexp[i] = merge_bytes(fill_word(addr), wdata, be);
            bus_write(addr, be, wdata);
            if (xif_last_req.addr !== addr)
                report_mismatch("xif_req_data_o.addr", addr, xif_last_req.addr);
            if (xif_last_req.wdata !== wdata)
                report_mismatch("xif_req_data_o.wdata", wdata, xif_last_req.wdata);
            if (xif_last_req.be !== be)
                report_mismatch("xif_req_data_o.be", 32'(be), 32'(xif_last_req.be));
            if (wait_cycles < xif_last_delay + 1)
            begin
                $display("host accepted after %0d stall cycles, expansion held off %0d",
                         wait_cycles, xif_last_delay + 1);
                errors = errors + 1;
            end
        end
        for (int i = 0; i < 6; i++)
        begin
            bus_read(XIF_BASE + 32'(4 * i), rd);
            if (rd !== xexp[i])
                report_mismatch("hif_rdata_o", xexp[i], rd);
        end
        // bit 31 wins over the sfr select bit
        addr = XIF_BASE | (32'd1 << `TILE_SFR_BITSEL) | 32'h0000_0040;
        bus_read(addr, rd);
        if (rd !== fill_word(addr))
            report_mismatch("hif_rdata_o", fill_word(addr), rd);
        for (int i = 0; i < 8; i++)
        begin
            bus_read(RAM_BASE + 32'(4 * i), rd);
            if (rd !== ram_model[i])
                report_mismatch("hif_rdata_o", ram_model[i], rd);
        end
        close_test("xif", e0);
    endtask

    task automatic irq_test();
        int          e0;
        logic [15:0] enabled;
        logic [15:0] raised;
        e0 = errors;
        enabled = 16'h002c;
        raised = 16'h00ad;
        bus_write(sfr_addr(`TILE_SFR_IRQEN), 4'hf, {16'd0, enabled});
        pulse_lines(raised);
        for (int b = 0; b < 16; b++)
        begin
            if (enabled[b] && raised[b])
            begin
                if (irq_req !== 1'b1)
                    report_mismatch("irq_req_o", 32'd1, 32'(irq_req));
                if (irq_code !== 4'(b))
                    report_mismatch("irq_code_o", 32'(b), 32'(irq_code));
                ack_irq();
            end
        end
        if (irq_req !== 1'b0)
            report_mismatch("irq_req_o", 32'd0, 32'(irq_req));

        pulse_lines(16'hf0d3);
        repeat (3)
        begin
            if (irq_req !== 1'b0)
                report_mismatch("irq_req_o", 32'd0, 32'(irq_req));
            wait_sample();
        end

        // held line 4 followed by a software reset
        bus_write(sfr_addr(`TILE_SFR_IRQEN), 4'hf, 32'h0000_0010);
        @(negedge clk);
        irq_lines = 16'h0010;
        #(SAMPLE_DLY);
        wait_sample();
        if (irq_req !== 1'b1)
            report_mismatch("irq_req_o", 32'd1, 32'(irq_req));
        if (irq_code !== 4'd4)
            report_mismatch("irq_code_o", 32'd4, 32'(irq_code));
        ack_irq();
        if (irq_req !== 1'b0)
            report_mismatch("irq_req_o", 32'd0, 32'(irq_req));
        wait_sample();
        if (irq_req !== 1'b1)
            report_mismatch("irq_req_o", 32'd1, 32'(irq_req));
        if (irq_code !== 4'd4)
            report_mismatch("irq_code_o", 32'd4, 32'(irq_code));
        bus_write(sfr_addr(`TILE_SFR_SWRST), 4'hf, 32'd1);
        #(SAMPLE_DLY);
        if (irq_req !== 1'b1)
            report_mismatch("irq_req_o", 32'd1, 32'(irq_req));
        repeat (2)
        begin
            wait_sample();
            if (irq_req !== 1'b0)
                report_mismatch("irq_req_o", 32'd0, 32'(irq_req));
        end
        @(negedge clk);
        irq_lines = '0;
        bus_write(sfr_addr(`TILE_SFR_SWRST), 4'hf, 32'd0);
        bus_write(sfr_addr(`TILE_SFR_IRQEN), 4'hf, 32'd0);
        #(SAMPLE_DLY);
        if (irq_req !== 1'b0)
            report_mismatch("irq_req_o", 32'd0, 32'(irq_req));
        close_test("irq", e0);
    endtask

    task automatic timer_sgi_test();
        int          e0;
        int          n;
        int          start;
        int          elapsed;
        logic [31:0] sgi_word;
        logic [31:0] rd;
        e0 = errors;
        sgi_word = 32'h0000_0019;
        bus_write(sfr_addr(`TILE_SFR_TVALUE), 4'hf, 32'd0);
        bus_write(sfr_addr(`TILE_SFR_IRQEN), 4'hf, 32'h0000_0002);
        bus_write(sfr_addr(`TILE_SFR_TPERIOD), 4'hf, 32'(TIMER_P));
        start = accept_cycle;
        n = 0;
        #(SAMPLE_DLY);
        while (!irq_req && (n < 4 * TIMER_P))
        begin
            n = n + 1;
            wait_sample();
        end
        if (!irq_req)
        begin
            $display("timer interrupt never rose");
            errors = errors + 1;
        end
        else
        begin
            elapsed = cycles - start - 1;
            if (elapsed > TIMER_P + 1)
            begin
                $display("timer interrupt took %0d cycles, limit %0d", elapsed, TIMER_P + 1);
                errors = errors + 1;
            end
            if (irq_code !== 4'd1)
                report_mismatch("irq_code_o", 32'd1, 32'(irq_code));
        end
        bus_write(sfr_addr(`TILE_SFR_TPERIOD), 4'hf, 32'd0);
        bus_write(sfr_addr(`TILE_SFR_IRQEN), 4'hf, 32'd0);
        #(SAMPLE_DLY);
        n = 0;
        while (irq_req && (n < 4))
        begin
            ack_irq();
            n = n + 1;
        end
        if (irq_req !== 1'b0)
            report_mismatch("irq_req_o", 32'd0, 32'(irq_req));

        // sgi ignores the cleared mask
        bus_write(sfr_addr(`TILE_SFR_SGI), 4'hf, sgi_word);
        #(SAMPLE_DLY);
        if (irq_req !== 1'b0)
            report_mismatch("irq_req_o", 32'd0, 32'(irq_req));
        wait_sample();
        if (irq_req !== 1'b1)
            report_mismatch("irq_req_o", 32'd1, 32'(irq_req));
        if (irq_code !== sgi_word[3:0])
            report_mismatch("irq_code_o", 32'(sgi_word[3:0]), 32'(irq_code));
        ack_irq();
        if (irq_req !== 1'b0)
            report_mismatch("irq_req_o", 32'd0, 32'(irq_req));
        bus_read(sfr_addr(`TILE_SFR_SGI), rd);
        if (rd !== 32'd0)
            report_mismatch("hif_rdata_o", 32'd0, rd);
        close_test("timer_sgi", e0);
    endtask

    // expansion slave with random accept and response delays
    initial
    begin : xif_model
        int       ack_dly;
        int       resp_dly;
        mem_req_t req;
        xif_ack   = 1'b0;
        xif_resp  = 1'b0;
        xif_rdata = 32'd0;
        forever
        begin
            @(negedge clk);
            #(SAMPLE_DLY);
            if (xif_req)
            begin
                req = xif_req_data;
                ack_dly = int'($unsigned($random(seed)) % 32'd4);
                xif_last_delay = ack_dly;
                repeat (ack_dly) @(negedge clk);
                @(negedge clk);
                xif_ack = 1'b1;
                xif_last_req = req;
                @(negedge clk);
                xif_ack = 1'b0;
                if (req.we)
                    xif_mem[{req.addr[31:2], 2'b00}] =
                        merge_bytes(model_word(req.addr), req.wdata, req.be);
                else
                begin
                    resp_dly = 1 + int'($unsigned($random(seed)) % 32'd4);
                    repeat (resp_dly - 1) @(negedge clk);
                    xif_resp = 1'b1;
                    xif_rdata = model_word(req.addr);
                    @(negedge clk);
                    xif_resp = 1'b0;
                end
            end
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        int e0;
        clk          = 1'b0;
        reset        = 1'b1;
        hif_req      = 1'b0;
        hif_req_data = '0;
        irq_lines    = '0;
        irq_ack      = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        #(SAMPLE_DLY);
        e0 = errors;
        if (hif_ack !== 1'b0)
            report_mismatch("hif_ack_o", 32'd0, 32'(hif_ack));
        if (hif_resp !== 1'b0)
            report_mismatch("hif_resp_o", 32'd0, 32'(hif_resp));
        if (xif_req !== 1'b0)
            report_mismatch("xif_req_o", 32'd0, 32'(xif_req));
        if (irq_req !== 1'b0)
            report_mismatch("irq_req_o", 32'd0, 32'(irq_req));
        close_test("reset", e0);

        ram_test();
        sfr_test();
        xif_test();
        irq_test();
        timer_sgi_test();

        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+source
source/tile_pkg.sv
source/bus_router.sv
source/data_ram.sv
source/sfr_block.sv
source/irq_adapter.sv
source/host_tile.sv
tests/tile_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f vlog.f --top-module tile_tb -Mdir obj_dir -o tile_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tile_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0
